// ==== source/uart_bridge_pkg.sv ====
package uart_bridge_pkg;

    // Bus widths fixed by the UART core register port
    localparam int addr_w      = 32;
    localparam int data_w      = 32;
    localparam int id_w        = 4;
    localparam int lite_addr_w = 4;

    // CPU-side addresses of the UART registers
    localparam logic [addr_w-1:0] uart_data_addr = 32'h1FD0_03F8;
    localparam logic [addr_w-1:0] uart_stat_addr = 32'h1FD0_03FC;

    // Local register offsets of the core
    localparam logic [lite_addr_w-1:0] lite_rx_off   = 4'h0;
    localparam logic [lite_addr_w-1:0] lite_tx_off   = 4'h4;
    localparam logic [lite_addr_w-1:0] lite_stat_off = 4'h8;

    // Transmit FIFO takes byte 0 only
    localparam logic [data_w/8-1:0] lite_wstrb = 4'b0001;

    // Core status register bits
    localparam int stat_tx_full_bit  = 3;
    localparam int stat_rx_valid_bit = 0;

    // AR and AW request
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
    } axi_ax_t;

    // R response payload
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
    } rd_resp_t;

    // B response payload
    typedef struct packed {
        logic [id_w-1:0] id;
    } wr_resp_t;

    // Register targets behind the bridge
    typedef enum logic [1:0] {
        sel_none = 2'd0,
        sel_rx   = 2'd1,
        sel_stat = 2'd2,
        sel_tx   = 2'd3
    } reg_sel_t;

endpackage

// ==== source/uart_addr_map.sv ====
module uart_addr_map (
    input  logic [uart_bridge_pkg::addr_w-1:0]      addr,
    output uart_bridge_pkg::reg_sel_t               sel,
    output logic [uart_bridge_pkg::lite_addr_w-1:0] lite_addr,
    input  uart_bridge_pkg::reg_sel_t               rd_sel,
    input  logic [uart_bridge_pkg::data_w-1:0]      core_rdata,
    output logic [uart_bridge_pkg::data_w-1:0]      rd_data
);

    // Address decode
    always_comb begin
        if (addr == uart_bridge_pkg::uart_data_addr) begin
            sel       = uart_bridge_pkg::sel_rx;
            lite_addr = uart_bridge_pkg::lite_rx_off;
        end else if (addr == uart_bridge_pkg::uart_stat_addr) begin
            sel       = uart_bridge_pkg::sel_stat;
            lite_addr = uart_bridge_pkg::lite_stat_off;
        end else begin
            sel       = uart_bridge_pkg::sel_none;
            lite_addr = '0;
        end
    end

    // Read data formatting per register
    always_comb begin
        rd_data = '0;
        case (rd_sel)
            uart_bridge_pkg::sel_rx: begin
                // Receive FIFO holds one byte
                rd_data[7:0] = core_rdata[7:0];
            end
            uart_bridge_pkg::sel_stat: begin
                rd_data[0] = ~core_rdata[uart_bridge_pkg::stat_tx_full_bit];
                rd_data[1] = core_rdata[uart_bridge_pkg::stat_rx_valid_bit];
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule

// ==== source/resp_holder.sv ====
module resp_holder #(
    parameter type payload_t = logic
) (
    input  logic     clk_sys,
    input  logic     resetn_sys,
    input  logic     load,
    input  payload_t payload_in,
    output logic     valid,
    input  logic     ready,
    output payload_t payload
);

    always_ff @(posedge clk_sys) begin
        if (!resetn_sys) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (valid && ready) begin
            valid <= 1'b0;
        end
    end

    // Payload stays put while valid waits for ready
    always_ff @(posedge clk_sys) begin
        if (load) begin
            payload <= payload_in;
        end
    end

endmodule

// ==== source/read_channel_fsm.sv ====
module read_channel_fsm (
    input  logic                                    clk_sys,
    input  logic                                    resetn_sys,
    input  uart_bridge_pkg::axi_ax_t                ar,
    input  logic                                    ar_valid,
    output logic                                    ar_ready,
    input  logic                                    pending,
    output logic [uart_bridge_pkg::lite_addr_w-1:0] m_araddr,
    output logic                                    m_arvalid,
    input  logic                                    m_arready,
    input  logic [uart_bridge_pkg::data_w-1:0]      m_rdata,
    input  logic                                    m_rvalid,
    output logic                                    m_rready,
    output logic                                    resp_load,
    output uart_bridge_pkg::rd_resp_t               resp
);

    typedef enum logic [1:0] {
        st_idle,
        st_accepted,
        st_wait_on_read
    } state_t;

    state_t                                  state;
    uart_bridge_pkg::reg_sel_t               ar_sel;
    uart_bridge_pkg::reg_sel_t               sel_q;
    logic [uart_bridge_pkg::lite_addr_w-1:0] ar_lite_addr;
    logic [uart_bridge_pkg::id_w-1:0]        id_q;
    logic [uart_bridge_pkg::data_w-1:0]      rd_data;
    logic                                    ar_fire;
    logic                                    r_fire;

    uart_addr_map rd_map_i (
        .addr       (ar.addr),
        .sel        (ar_sel),
        .lite_addr  (ar_lite_addr),
        .rd_sel     (sel_q),
        .core_rdata (m_rdata),
        .rd_data    (rd_data)
    );

    assign ar_ready = (state == st_idle) && !pending;
    assign ar_fire  = ar_valid && ar_ready;
    assign r_fire   = (state == st_wait_on_read) && m_rvalid && m_rready;

    // Unmapped reads are answered straight from idle
    assign resp_load = (ar_fire && (ar_sel == uart_bridge_pkg::sel_none)) || r_fire;

    always_comb begin
        if (state == st_wait_on_read) begin
            resp.id   = id_q;
            resp.data = rd_data;
        end else begin
            resp.id   = ar.id;
            resp.data = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!resetn_sys) begin
            state     <= st_idle;
            m_arvalid <= 1'b0;
            m_rready  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (ar_fire && (ar_sel != uart_bridge_pkg::sel_none)) begin
                        state     <= st_accepted;
                        m_arvalid <= 1'b1;
                    end
                end
                st_accepted: begin
                    // Core may stall AR here
                    if (m_arready) begin
                        state     <= st_wait_on_read;
                        m_arvalid <= 1'b0;
                        m_rready  <= 1'b1;
                    end
                end
                st_wait_on_read: begin
                    if (r_fire) begin
                        state    <= st_idle;
                        m_rready <= 1'b0;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Request fields captured on the AR transfer
    always_ff @(posedge clk_sys) begin
        if (ar_fire) begin
            id_q     <= ar.id;
            sel_q    <= ar_sel;
            m_araddr <= ar_lite_addr;
        end
    end

endmodule

// ==== source/write_channel_fsm.sv ====
module write_channel_fsm (
    input  logic                                    clk_sys,
    input  logic                                    resetn_sys,
    input  uart_bridge_pkg::axi_ax_t                aw,
    input  logic                                    aw_valid,
    input  logic [uart_bridge_pkg::data_w-1:0]      wdata,
    input  logic                                    w_valid,
    output logic                                    aw_ready,
    output logic                                    w_ready,
    input  logic                                    pending,
    output logic [uart_bridge_pkg::lite_addr_w-1:0] m_awaddr,
    output logic                                    m_awvalid,
    input  logic                                    m_awready,
    output logic [uart_bridge_pkg::data_w-1:0]      m_wdata,
    output logic                                    m_wvalid,
    input  logic                                    m_wready,
    output logic                                    resp_load,
    output uart_bridge_pkg::wr_resp_t               resp
);

    typedef enum logic {
        st_idle,
        st_accepted
    } state_t;

    state_t                           state;
    uart_bridge_pkg::reg_sel_t        aw_sel;
    uart_bridge_pkg::reg_sel_t        wr_sel;
    logic [uart_bridge_pkg::id_w-1:0] id_q;
    logic [7:0]                       wbyte_q;
    logic                             aw_fire;
    logic                             m_fire;

    uart_addr_map wr_map_i (
        .addr       (aw.addr),
        .sel        (aw_sel),
        .lite_addr  (),
        .rd_sel     (uart_bridge_pkg::sel_none),
        .core_rdata ('0),
        .rd_data    ()
    );

    // Both mapped addresses end up in the transmit FIFO
    assign wr_sel = (aw_sel == uart_bridge_pkg::sel_none) ? uart_bridge_pkg::sel_none
                                                          : uart_bridge_pkg::sel_tx;

    assign aw_fire  = aw_valid && w_valid && (state == st_idle) && !pending;
    assign aw_ready = aw_fire;
    assign w_ready  = aw_fire;
    assign m_fire   = (state == st_accepted) && m_awready && m_wready;

    assign resp_load = (aw_fire && (wr_sel == uart_bridge_pkg::sel_none)) || m_fire;
    assign resp.id   = (state == st_accepted) ? id_q : aw.id;

    assign m_wdata = {{(uart_bridge_pkg::data_w-8){1'b0}}, wbyte_q};

    always_ff @(posedge clk_sys) begin
        if (!resetn_sys) begin
            state     <= st_idle;
            m_awvalid <= 1'b0;
            m_wvalid  <= 1'b0;
        end else if ((state == st_idle) && aw_fire && (wr_sel == uart_bridge_pkg::sel_tx)) begin
            state     <= st_accepted;
            m_awvalid <= 1'b1;
            m_wvalid  <= 1'b1;
        end else if (m_fire) begin
            // Core takes AW and W in the same cycle
            state     <= st_idle;
            m_awvalid <= 1'b0;
            m_wvalid  <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (aw_fire) begin
            id_q     <= aw.id;
            wbyte_q  <= wdata[7:0];
            m_awaddr <= uart_bridge_pkg::lite_tx_off;
        end
    end

endmodule

// ==== source/uart_axi_bridge.sv ====
module uart_axi_bridge (
    input  logic                                    clk_sys,
    input  logic                                    resetn_sys,

    // AXI4 slave side
    input  uart_bridge_pkg::axi_ax_t                s_ar,
    input  logic                                    s_arvalid,
    output logic                                    s_arready,
    output uart_bridge_pkg::rd_resp_t               s_r,
    output logic [1:0]                              s_rresp,
    output logic                                    s_rlast,
    output logic                                    s_rvalid,
    input  logic                                    s_rready,
    input  uart_bridge_pkg::axi_ax_t                s_aw,
    input  logic                                    s_awvalid,
    output logic                                    s_awready,
    input  logic [uart_bridge_pkg::data_w-1:0]      s_wdata,
    input  logic                                    s_wvalid,
    output logic                                    s_wready,
    output uart_bridge_pkg::wr_resp_t               s_b,
    output logic [1:0]                              s_bresp,
    output logic                                    s_bvalid,
    input  logic                                    s_bready,

    // AXI4-Lite side towards the UART core
    output logic [uart_bridge_pkg::lite_addr_w-1:0] m_araddr,
    output logic                                    m_arvalid,
    input  logic                                    m_arready,
    input  logic [uart_bridge_pkg::data_w-1:0]      m_rdata,
    input  logic                                    m_rvalid,
    output logic                                    m_rready,
    output logic [uart_bridge_pkg::lite_addr_w-1:0] m_awaddr,
    output logic                                    m_awvalid,
    input  logic                                    m_awready,
    output logic [uart_bridge_pkg::data_w-1:0]      m_wdata,
    output logic [uart_bridge_pkg::data_w/8-1:0]    m_wstrb,
    output logic                                    m_wvalid,
    input  logic                                    m_wready,
    output logic                                    m_bready
);

    logic                      rd_load;
    uart_bridge_pkg::rd_resp_t rd_payload;
    logic                      wr_load;
    uart_bridge_pkg::wr_resp_t wr_payload;

    // Single beats only, always OKAY
    assign s_rresp  = 2'b00;
    assign s_rlast  = 1'b1;
    assign s_bresp  = 2'b00;
    assign m_wstrb  = uart_bridge_pkg::lite_wstrb;
    // Core write responses are dropped
    assign m_bready = 1'b1;

    read_channel_fsm rd_fsm_i (
        .clk_sys    (clk_sys),
        .resetn_sys (resetn_sys),
        .ar         (s_ar),
        .ar_valid   (s_arvalid),
        .ar_ready   (s_arready),
        .pending    (s_rvalid),
        .m_araddr   (m_araddr),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .m_rdata    (m_rdata),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready),
        .resp_load  (rd_load),
        .resp       (rd_payload)
    );

    write_channel_fsm wr_fsm_i (
        .clk_sys    (clk_sys),
        .resetn_sys (resetn_sys),
        .aw         (s_aw),
        .aw_valid   (s_awvalid),
        .wdata      (s_wdata),
        .w_valid    (s_wvalid),
        .aw_ready   (s_awready),
        .w_ready    (s_wready),
        .pending    (s_bvalid),
        .m_awaddr   (m_awaddr),
        .m_awvalid  (m_awvalid),
        .m_awready  (m_awready),
        .m_wdata    (m_wdata),
        .m_wvalid   (m_wvalid),
        .m_wready   (m_wready),
        .resp_load  (wr_load),
        .resp       (wr_payload)
    );

    resp_holder #(.payload_t(uart_bridge_pkg::rd_resp_t)) rd_holder_i (
        .clk_sys    (clk_sys),
        .resetn_sys (resetn_sys),
        .load       (rd_load),
        .payload_in (rd_payload),
        .valid      (s_rvalid),
        .ready      (s_rready),
        .payload    (s_r)
    );

    resp_holder #(.payload_t(uart_bridge_pkg::wr_resp_t)) wr_holder_i (
        .clk_sys    (clk_sys),
        .resetn_sys (resetn_sys),
        .load       (wr_load),
        .payload_in (wr_payload),
        .valid      (s_bvalid),
        .ready      (s_bready),
        .payload    (s_b)
    );

endmodule

// ==== verif/uart_bridge_properties.sv ====
module uart_bridge_properties (
    input logic clk_sys,
    input logic resetn_sys,
    input logic req_valid,
    input logic req_ready,
    input logic side_valid,
    input logic resp_ready,
    input logic pair_en,
    input logic overlap_en
);
    timeunit 1ns;
    timeprecision 1ps;

    // A request stays up until the core takes it
    req_held_a: assert property (
        @(posedge clk_sys) disable iff (!resetn_sys)
        req_valid && !req_ready |=> req_valid
    ) else $error("request valid dropped before ready");

    // Paired valids move together
    pair_aligned_a: assert property (
        @(posedge clk_sys) disable iff (!resetn_sys)
        pair_en |-> (req_valid == side_valid)
    ) else $error("paired valids out of step");

    // Read data only taken once the address phase is over
    no_overlap_a: assert property (
        @(posedge clk_sys) disable iff (!resetn_sys)
        overlap_en |-> !(resp_ready && req_valid)
    ) else $error("response ready high while request still pending");

endmodule

// ==== verif/tb_uart_axi_bridge.sv ====
module tb_uart_axi_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 4;
    localparam int n_tests    = 11;

    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        logic [3:0]  id;
        logic [31:0] wdata;
        logic [31:0] core_val;
        logic [31:0] exp_data;
        logic        exp_core;
        logic [3:0]  exp_off;
    } test_t;

    logic                      clk_sys = 1'b0;
    logic                      resetn_sys;
    logic                      s_arvalid, s_arready, s_rlast, s_rvalid, s_rready;
    logic                      s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic [1:0]                s_rresp, s_bresp;
    logic [31:0]               s_wdata, m_rdata, m_wdata;
    logic [3:0]                m_araddr, m_awaddr, m_wstrb;
    logic                      m_arvalid, m_arready, m_rvalid, m_rready;
    logic                      m_awvalid, m_awready, m_wvalid, m_wready, m_bready;
    uart_bridge_pkg::axi_ax_t  s_ar, s_aw;
    uart_bridge_pkg::rd_resp_t s_r;
    uart_bridge_pkg::wr_resp_t s_b;

    test_t       tests [n_tests];
    logic [31:0] core_val;
    int          delays [256];
    int          delay_idx = 0;
    int          error_count = 0;
    logic [3:0]  core_ar_q [$];
    logic [3:0]  core_aw_q [$];
    logic [7:0]  core_wbyte_q [$];
    logic [3:0]  core_wstrb_q [$];

    uart_axi_bridge dut_i (.*);

    bind read_channel_fsm uart_bridge_properties rd_props_i (
        .clk_sys (clk_sys), .resetn_sys (resetn_sys),
        .req_valid (m_arvalid), .req_ready (m_arready),
        .side_valid (1'b0), .resp_ready (m_rready),
        .pair_en (1'b0), .overlap_en (1'b1)
    );
    bind write_channel_fsm uart_bridge_properties wr_props_i (
        .clk_sys (clk_sys), .resetn_sys (resetn_sys),
        .req_valid (m_awvalid), .req_ready (m_awready && m_wready),
        .side_valid (m_wvalid), .resp_ready (1'b0),
        .pair_en (1'b1), .overlap_en (1'b0)
    );

    always #(clk_period / 2) clk_sys = ~clk_sys;

    function automatic int next_delay();
        int d;
        d = delays[delay_idx];
        delay_idx = (delay_idx + 1) % 256;
        return d;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic send_request(input test_t t);
        logic accepted;
        accepted = 1'b0;
        if (t.is_write) begin
            s_aw      = '{id: t.id, addr: t.addr};
            s_wdata   = t.wdata;
            s_awvalid = 1'b1;
            s_wvalid  = 1'b1;
        end else begin
            s_ar      = '{id: t.id, addr: t.addr};
            s_arvalid = 1'b1;
        end
        while (!accepted) begin
            #1;
            accepted = t.is_write ? (s_awready && s_wready) : s_arready;
            @(negedge clk_sys);
        end
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        s_arvalid = 1'b0;
    endtask

    task automatic take_response(input test_t t, input int hold,
                                 output logic [3:0] id, output logic [31:0] data);
        while (!(t.is_write ? s_bvalid : s_rvalid)) begin
            @(negedge clk_sys);
        end
        id   = t.is_write ? s_b.id : s_r.id;
        data = t.is_write ? 32'd0 : s_r.data;
        check_value("response code", 32'(t.is_write ? s_bresp : s_rresp), 32'd0);
        if (!t.is_write) begin
            check_value("rlast", 32'(s_rlast), 32'd1);
        end
        // Same request offered again while the master stalls
        repeat (hold) begin
            s_awvalid = t.is_write;
            s_wvalid  = t.is_write;
            s_arvalid = !t.is_write;
            #1;
            if (t.is_write) begin
                check_value("held B", 32'({s_bvalid, s_b.id}), 32'({1'b1, id}));
                check_value("AW/W ready under stall", 32'({s_awready, s_wready}), 32'd0);
            end else begin
                check_value("held R", 32'({s_rvalid, s_r.id}), 32'({1'b1, id}));
                check_value("held R data", s_r.data, data);
                check_value("AR ready under stall", 32'(s_arready), 32'd0);
            end
            @(negedge clk_sys);
        end
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        s_arvalid = 1'b0;
        s_bready  = t.is_write;
        s_rready  = !t.is_write;
        @(negedge clk_sys);
        s_bready = 1'b0;
        s_rready = 1'b0;
        check_value("valid after transfer", 32'(t.is_write ? s_bvalid : s_rvalid), 32'd0);
    endtask

    // UART core model, read side
    initial begin : core_read_model
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_rdata   = '0;
        forever begin
            @(negedge clk_sys);
            if (m_arvalid) begin
                repeat (next_delay()) @(negedge clk_sys);
                m_arready = 1'b1;
                core_ar_q.push_back(m_araddr);
                @(negedge clk_sys);
                m_arready = 1'b0;
                repeat (next_delay()) @(negedge clk_sys);
                m_rdata  = core_val;
                m_rvalid = 1'b1;
                @(negedge clk_sys);
                m_rvalid = 1'b0;
            end
        end
    end

    // UART core model, write side takes AW and W together
    initial begin : core_write_model
        m_awready = 1'b0;
        m_wready  = 1'b0;
        forever begin
            @(negedge clk_sys);
            if (m_awvalid) begin
                repeat (next_delay()) @(negedge clk_sys);
                m_awready = 1'b1;
                m_wready  = 1'b1;
                core_aw_q.push_back(m_awaddr);
                core_wbyte_q.push_back(m_wdata[7:0]);
                core_wstrb_q.push_back(m_wstrb);
                @(negedge clk_sys);
                m_awready = 1'b0;
                m_wready  = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #((n_tests * 40 + 8) * clk_period);
        $display("Timeout: the bridge stopped answering before all tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin : stimulus
        test_t       t;
        string       kind;
        int          n_ar;
        int          n_aw;
        int          errors_before;
        int          failed_tests;
        logic [3:0]  got_id;
        logic [31:0] got_data;
        failed_tests = 0;
        void'($urandom(94037));
        for (int i = 0; i < 256; i++) begin
            delays[i] = $urandom_range(0, 3);
        end
        resetn_sys = 1'b0;
        s_ar       = '0;
        s_aw       = '0;
        s_wdata    = '0;
        s_arvalid  = 1'b0;
        s_awvalid  = 1'b0;
        s_wvalid   = 1'b0;
        s_rready   = 1'b0;
        s_bready   = 1'b0;
        core_val   = '0;
        // write, addr, id, wdata, core value, expected data or byte, core hit, offset
        tests = '{
            '{1'b1, 32'h1FD0_03F8, 4'd3,  32'hDEAD_BEA5, 32'h0000_0000, 32'hA5, 1'b1, 4'h4},
            '{1'b1, 32'h1FD0_03FC, 4'd5,  32'h1234_5678, 32'h0000_0000, 32'h78, 1'b1, 4'h4},
            '{1'b1, 32'h1FD0_0400, 4'd9,  32'hCAFE_F00D, 32'h0000_0000, 32'h00, 1'b0, 4'h0},
            '{1'b0, 32'h1FD0_03F8, 4'd1,  32'h0000_0000, 32'hABCD_EF5A, 32'h5A, 1'b1, 4'h0},
            '{1'b0, 32'h1FD0_03FC, 4'd2,  32'h0000_0000, 32'h0000_0000, 32'h01, 1'b1, 4'h8},
            '{1'b0, 32'h1FD0_03FC, 4'd6,  32'h0000_0000, 32'hFFFF_FFF7, 32'h03, 1'b1, 4'h8},
            '{1'b0, 32'h1FD0_03FC, 4'd10, 32'h0000_0000, 32'h0000_0008, 32'h00, 1'b1, 4'h8},
            '{1'b0, 32'h1FD0_03FC, 4'd12, 32'h0000_0000, 32'hFFFF_FFFF, 32'h02, 1'b1, 4'h8},
            '{1'b0, 32'h0000_0000, 4'd7,  32'h0000_0000, 32'h1234_5678, 32'h00, 1'b0, 4'h0},
            '{1'b0, 32'h1FD0_03F4, 4'd11, 32'h0000_0000, 32'hFFFF_FFFF, 32'h00, 1'b0, 4'h0},
            '{1'b1, 32'h1FD0_03F8, 4'd15, 32'h0000_00FF, 32'h0000_0000, 32'hFF, 1'b1, 4'h4}
        };
        repeat (4) @(negedge clk_sys);
        check_value("valids in reset",
                    32'({s_rvalid, s_bvalid, m_arvalid, m_awvalid, m_wvalid, m_rready}), 32'd0);
        // Core write responses are always accepted
        check_value("core bready", 32'(m_bready), 32'd1);
        resetn_sys = 1'b1;
        @(negedge clk_sys);

        for (int i = 0; i < n_tests; i++) begin
            t             = tests[i];
            n_ar          = core_ar_q.size();
            n_aw          = core_aw_q.size();
            errors_before = error_count;
            core_val      = t.core_val;
            send_request(t);
            take_response(t, $urandom_range(0, 3), got_id, got_data);
            check_value("response id", 32'(got_id), 32'(t.id));
            check_value("core AR count", 32'(core_ar_q.size() - n_ar),
                        t.is_write ? 32'd0 : 32'(t.exp_core));
            check_value("core AW count", 32'(core_aw_q.size() - n_aw),
                        t.is_write ? 32'(t.exp_core) : 32'd0);
            if (t.is_write) begin
                kind = "write";
                if (t.exp_core && core_aw_q.size() > n_aw) begin
                    check_value("core AW offset", 32'(core_aw_q[n_aw]), 32'(t.exp_off));
                    check_value("core W byte", 32'(core_wbyte_q[n_aw]), t.exp_data);
                    check_value("core W strobe", 32'(core_wstrb_q[n_aw]), 32'h1);
                end
            end else begin
                kind = "read";
                check_value("read data", got_data, t.exp_data);
                if (t.exp_core && core_ar_q.size() > n_ar) begin
                    check_value("core AR offset", 32'(core_ar_q[n_ar]), 32'(t.exp_off));
                end
            end
            if (error_count != errors_before) begin
                failed_tests++;
            end
            $display("test %0d %s %h id %0d: %s", i, kind, t.addr, t.id,
                     (error_count == errors_before) ? "ok" : "FAILED");
        end

        $display("%0d tests run, %0d failed, %0d check errors", n_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/uart_bridge_pkg.sv
source/uart_addr_map.sv
source/resp_holder.sv
source/read_channel_fsm.sv
source/write_channel_fsm.sv
source/uart_axi_bridge.sv
verif/uart_bridge_properties.sv
verif/tb_uart_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_uart_axi_bridge -f sources.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || {
    cat sim.log
    echo "simulation exited with an error"
    exit 1
}
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
